// ==== tb.f ====
hdl/seq_cfg_pkg.sv
hdl/seq_ctrl_pkg.sv
hdl/slot_if.sv
hdl/seq_slot_table.sv
hdl/seq_slot_access.sv
hdl/seq_ctrl_fsm.sv
hdl/seq_top.sv
tests/tb_clk_gen.sv
tests/tb_seq_top.sv

// ==== Bender.yml ====
package:
  name: seq_slot_sequencer

sources:
  - hdl/seq_cfg_pkg.sv
  - hdl/seq_ctrl_pkg.sv
  - hdl/slot_if.sv
  - hdl/seq_slot_table.sv
  - hdl/seq_slot_access.sv
  - hdl/seq_ctrl_fsm.sv
  - hdl/seq_top.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_seq_top.sv

// ==== tests/tb_seq_top.sv ====
`timescale 1ns/1ps

module tb_seq_top;

    localparam int run_limit = 400;  // cycles, bound on every wait loop

    logic clk;
    logic reset;
    seq_cfg_pkg::slot_index_t  wr_index, rd_index, end_cnt_in, end_cnt_out, slot_cnt;
    seq_cfg_pkg::addr_t        wr_src_addr, wr_dst_addr, rd_src_addr, rd_dst_addr;
    seq_cfg_pkg::size_t        wr_src_size, wr_dst_size, rd_src_size, rd_dst_size;
    seq_cfg_pkg::slot_status_t wr_status, rd_status, dma_status;
    seq_cfg_pkg::profile_t     wr_profile, rd_profile, dma_profile;
    seq_cfg_pkg::addr_t        dma_src_addr, dma_dst_addr;
    seq_cfg_pkg::size_t        dma_src_size, dma_dst_size;
    seq_cfg_pkg::init_task_t   init_task, init_done;
    seq_ctrl_pkg::ctrl_cmd_t   ctrl_cmd;
    logic [3:0]                state_out;
    logic set_src_addr, set_src_size, set_dst_addr, set_dst_size, set_status, set_profile;
    logic set_done_src_addr, set_done_src_size, set_done_dst_addr, set_done_dst_size;
    logic set_done_status, set_done_profile;
    logic rd_req, rd_ready, ctrl_set, end_cnt_set;
    logic reprog, reprog_accept, exec_start, exec_done;

    logic [5:0] set_vec;   // strobes, src_addr in bit 0
    logic [5:0] done_vec;  // acks, same order
    assign {set_profile, set_status, set_dst_size, set_dst_addr, set_src_size,
            set_src_addr} = set_vec;
    assign done_vec = {set_done_profile, set_done_status, set_done_dst_size,
                       set_done_dst_addr, set_done_src_size, set_done_src_addr};

    // expected slot table contents
    seq_cfg_pkg::addr_t        exp_src_addr [seq_cfg_pkg::slot_n];
    seq_cfg_pkg::size_t        exp_src_size [seq_cfg_pkg::slot_n];
    seq_cfg_pkg::addr_t        exp_dst_addr [seq_cfg_pkg::slot_n];
    seq_cfg_pkg::size_t        exp_dst_size [seq_cfg_pkg::slot_n];
    seq_cfg_pkg::slot_status_t exp_status   [seq_cfg_pkg::slot_n];
    seq_cfg_pkg::profile_t     exp_profile  [seq_cfg_pkg::slot_n];

    seq_cfg_pkg::slot_index_t reprog_log [$];  // slot_cnt at each reprog request
    seq_cfg_pkg::slot_index_t exec_log   [$];  // slot_cnt at each exec_start
    seq_cfg_pkg::init_task_t  init_log   [$];  // init_task as each task is served
    int err_cnt     = 0;
    int timeout_cnt = 0;
    int check_cnt   = 0;

    tb_clk_gen clk_gen0 (.clk(clk), .reset(reset));

    seq_top dut0 (.*);

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clk);
        #2;  // drive point
    endtask

    task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
        check_cnt++;
        assert (act === exp) else begin
            err_cnt++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // state only moves at the edge, so the drive point is a safe place to look
    task automatic wait_for(logic [3:0] st, seq_cfg_pkg::slot_index_t slot, string what);
        int n;
        for (n = 0; n < run_limit; n++) begin
            if (state_out == st && slot_cnt == slot) break;
            next_cycle();
        end
        assert (n < run_limit) else begin
            timeout_cnt++;
            $display("timeout after %0d cycles waiting for %s", n, what);
        end
    endtask

    task automatic send_cmd(seq_ctrl_pkg::ctrl_cmd_t cmd);
        ctrl_cmd = cmd;
        ctrl_set = 1'b1;
        next_cycle();
        ctrl_set = 1'b0;
    endtask

    task automatic write_end_count(seq_cfg_pkg::slot_index_t cnt);
        end_cnt_in  = cnt;
        end_cnt_set = 1'b1;
        next_cycle();
        end_cnt_set = 1'b0;
    endtask

    // random fields into one slot, one strobe per cycle
    task automatic host_write(seq_cfg_pkg::slot_index_t idx, bit expect_ack);
        wr_index    = idx;
        wr_src_addr = $urandom;
        wr_src_size = seq_cfg_pkg::size_t'($urandom);
        wr_dst_addr = $urandom;
        wr_dst_size = seq_cfg_pkg::size_t'($urandom);
        wr_status   = seq_cfg_pkg::slot_status_t'($urandom);
        wr_profile  = $urandom;
        for (int f = 0; f < 6; f++) begin
            set_vec = 6'b1 << f;
            #1;  // ack is combinational
            check_val($sformatf("set_done field %0d", f), {6{expect_ack}} & set_vec, done_vec);
            next_cycle();  // write lands here
        end
        set_vec = '0;
        if (expect_ack) begin
            exp_src_addr[idx] = wr_src_addr;
            exp_src_size[idx] = wr_src_size;
            exp_dst_addr[idx] = wr_dst_addr;
            exp_dst_size[idx] = wr_dst_size;
            exp_status[idx]   = wr_status;
            exp_profile[idx]  = wr_profile;
        end
    endtask

    task automatic read_slot_check(seq_cfg_pkg::slot_index_t idx, bit expect_ready);
        rd_index = idx;
        rd_req   = 1'b1;
        #1;
        check_val("rd_ready", expect_ready, rd_ready);
        if (expect_ready) begin  // data is only meaningful with ready
            check_val($sformatf("rd_src_addr[%0d]", idx), exp_src_addr[idx], rd_src_addr);
            check_val($sformatf("rd_src_size[%0d]", idx), exp_src_size[idx], rd_src_size);
            check_val($sformatf("rd_dst_addr[%0d]", idx), exp_dst_addr[idx], rd_dst_addr);
            check_val($sformatf("rd_dst_size[%0d]", idx), exp_dst_size[idx], rd_dst_size);
            check_val($sformatf("rd_status[%0d]", idx), exp_status[idx], rd_status);
            check_val($sformatf("rd_profile[%0d]", idx), exp_profile[idx], rd_profile);
        end
        next_cycle();
        rd_req = 1'b0;
    endtask

    // dma side model, samples 1 ns after the edge and drives 1 ns later
    task automatic dma_responder();
        int  acc_wait  = 0;  // cycles until reprog_accept is seen
        int  init_wait = 0;
        int  exec_wait = 0;
        bit  reprog_seen = 1'b0;
        seq_cfg_pkg::init_task_t init_pend = '0;
        forever begin
            @(posedge clk);
            #1;
            if (state_out != 0) begin  // current slot is shown to the dma
                check_val($sformatf("dma_src_addr[%0d]", slot_cnt), exp_src_addr[slot_cnt],
                          dma_src_addr);
                check_val($sformatf("dma_src_size[%0d]", slot_cnt), exp_src_size[slot_cnt],
                          dma_src_size);
                check_val($sformatf("dma_dst_addr[%0d]", slot_cnt), exp_dst_addr[slot_cnt],
                          dma_dst_addr);
                check_val($sformatf("dma_dst_size[%0d]", slot_cnt), exp_dst_size[slot_cnt],
                          dma_dst_size);
                check_val($sformatf("dma_status[%0d]", slot_cnt), exp_status[slot_cnt],
                          dma_status);
                // profile is one up once the reprogram of this slot was accepted
                check_val($sformatf("dma_profile[%0d]", slot_cnt),
                          exp_profile[slot_cnt] + (state_out != seq_ctrl_pkg::st_reprog),
                          dma_profile);
            end
            if (reprog && !reprog_seen) begin
                reprog_log.push_back(slot_cnt);
                acc_wait = 1 + $urandom % 3;
            end
            reprog_seen = reprog;  // one log per request
            if (init_task != '0 && init_wait == 0) begin
                init_log.push_back(init_task);
                init_pend = init_task;
                init_wait = 1 + $urandom % 3;
            end
            if (exec_start) begin
                exec_log.push_back(slot_cnt);
                exec_wait = 2 + $urandom % 4;  // a done during trigger itself is ignored
            end
            #1;
            reprog_accept = (acc_wait == 1);
            init_done     = (init_wait == 1) ? init_pend : '0;
            exec_done     = (exec_wait == 1);
            if (acc_wait > 0) acc_wait--;
            if (init_wait > 0) init_wait--;
            if (exec_wait > 0) exec_wait--;
        end
    endtask

    //////////////////////////////////////////////////
    // behaviors
    //////////////////////////////////////////////////

    task automatic write_read_back();
        for (int i = 0; i < seq_cfg_pkg::slot_n; i++) begin
            host_write(i, 1'b1);
        end
        for (int i = 0; i < seq_cfg_pkg::slot_n; i++) begin
            read_slot_check(i, 1'b1);
        end
    endtask

    task automatic run_three_slots();
        reprog_log.delete();
        init_log.delete();
        exec_log.delete();
        write_end_count(2);
        check_val("end_cnt_out", 2, end_cnt_out);
        send_cmd(seq_ctrl_pkg::cmd_start);
        check_val("state_out", seq_ctrl_pkg::st_reprog, state_out);
        wait_for(seq_ctrl_pkg::st_shutdown, 0, "the end of the run");
        check_val("reprog request count", 3, reprog_log.size());
        check_val("exec_start count", 3, exec_log.size());
        check_val("init step count", 18, init_log.size());
        foreach (reprog_log[i]) check_val($sformatf("reprog slot #%0d", i), i, reprog_log[i]);
        foreach (exec_log[i]) check_val($sformatf("exec_start slot #%0d", i), i, exec_log[i]);
        foreach (init_log[i]) check_val($sformatf("init_task #%0d", i), 1 << (i % 6), init_log[i]);
        for (int i = 0; i < 3; i++) begin
            exp_profile[i]++;  // one accepted reprogram each
        end
    endtask

    task automatic profile_count();
        for (int i = 0; i < seq_cfg_pkg::slot_n; i++) begin
            read_slot_check(i, 1'b1);  // slot 3 keeps its written profile
        end
    endtask

    task automatic locked_during_run();
        send_cmd(seq_ctrl_pkg::cmd_start);
        host_write(1, 1'b0);
        read_slot_check(2, 1'b0);
        write_end_count(1);
        check_val("end_cnt_out", 2, end_cnt_out);
        assert (state_out != 0) else begin
            err_cnt++;
            $display("run ended before the locked checks were done");
        end
        wait_for(seq_ctrl_pkg::st_shutdown, 0, "the end of the locked run");
        for (int i = 0; i < 3; i++) begin
            exp_profile[i]++;
        end
        for (int i = 0; i < seq_cfg_pkg::slot_n; i++) begin
            read_slot_check(i, 1'b1);
        end
    endtask

    task automatic abort_run();
        send_cmd(seq_ctrl_pkg::cmd_start);
        wait_for(seq_ctrl_pkg::st_init, 1, "slot 1 in init");
        send_cmd(seq_ctrl_pkg::cmd_shutdown);
        check_val("state_out", seq_ctrl_pkg::st_shutdown, state_out);
        check_val("slot_cnt", 1, slot_cnt);  // counter kept
        send_cmd(seq_ctrl_pkg::cmd_clear);
        check_val("slot_cnt", 0, slot_cnt);
        check_val("init_task", 0, init_task);
    endtask

    initial begin
        int n;
        void'($urandom(32'h95c5_c51b));
        {wr_index, wr_src_addr, wr_src_size, wr_dst_addr, wr_dst_size, wr_status} = '0;
        {wr_profile, rd_index, rd_req, ctrl_set, end_cnt_in, end_cnt_set} = '0;
        {set_vec, reprog_accept, init_done, exec_done} = '0;
        ctrl_cmd = seq_ctrl_pkg::cmd_clear;
        for (n = 0; n < 10 && !reset; n++) begin
            @(posedge clk);
        end
        assert (reset) else begin
            timeout_cnt++;
            $display("timeout, reset was never released");
        end
        next_cycle();
        fork
            dma_responder();  // inherits the seeded generator
        join_none
        write_read_back();
        run_three_slots();
        profile_count();
        locked_during_run();
        abort_run();
        $display("checks %0d, value errors %0d, timeouts %0d", check_cnt, err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== tests/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic reset   // active low
);

    localparam int half_period = 20;  // 40 ns clock

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // held over two rising edges, released off the edge
    initial begin
        reset = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b1;
    end

endmodule

// ==== hdl/seq_top.sv ====
`timescale 1ns/1ps

module seq_top (
    input  logic                      clk,
    input  logic                      reset,
    // host slot writes
    input  seq_cfg_pkg::slot_index_t  wr_index,
    input  seq_cfg_pkg::addr_t        wr_src_addr,
    input  seq_cfg_pkg::size_t        wr_src_size,
    input  seq_cfg_pkg::addr_t        wr_dst_addr,
    input  seq_cfg_pkg::size_t        wr_dst_size,
    input  seq_cfg_pkg::slot_status_t wr_status,
    input  seq_cfg_pkg::profile_t     wr_profile,
    input  logic                      set_src_addr,
    input  logic                      set_src_size,
    input  logic                      set_dst_addr,
    input  logic                      set_dst_size,
    input  logic                      set_status,
    input  logic                      set_profile,
    output logic                      set_done_src_addr,
    output logic                      set_done_src_size,
    output logic                      set_done_dst_addr,
    output logic                      set_done_dst_size,
    output logic                      set_done_status,
    output logic                      set_done_profile,
    // host slot reads
    input  seq_cfg_pkg::slot_index_t  rd_index,
    input  logic                      rd_req,
    output logic                      rd_ready,
    output seq_cfg_pkg::addr_t        rd_src_addr,
    output seq_cfg_pkg::size_t        rd_src_size,
    output seq_cfg_pkg::addr_t        rd_dst_addr,
    output seq_cfg_pkg::size_t        rd_dst_size,
    output seq_cfg_pkg::slot_status_t rd_status,
    output seq_cfg_pkg::profile_t     rd_profile,
    // control and status
    input  seq_ctrl_pkg::ctrl_cmd_t   ctrl_cmd,
    input  logic                      ctrl_set,
    output logic [3:0]                state_out,
    output seq_cfg_pkg::slot_index_t  slot_cnt,
    input  seq_cfg_pkg::slot_index_t  end_cnt_in,
    input  logic                      end_cnt_set,
    output seq_cfg_pkg::slot_index_t  end_cnt_out,
    // dma side
    output logic                      reprog,
    input  logic                      reprog_accept,
    output seq_cfg_pkg::init_task_t   init_task,
    input  seq_cfg_pkg::init_task_t   init_done,
    output logic                      exec_start,
    input  logic                      exec_done,
    output seq_cfg_pkg::addr_t        dma_src_addr,
    output seq_cfg_pkg::size_t        dma_src_size,
    output seq_cfg_pkg::addr_t        dma_dst_addr,
    output seq_cfg_pkg::size_t        dma_dst_size,
    output seq_cfg_pkg::slot_status_t dma_status,
    output seq_cfg_pkg::profile_t     dma_profile
);

    seq_ctrl_pkg::seq_state_t state;
    logic                     reprog_accepted;  // fsm -> access, profile inc

    assign state_out = state;  // enum value is the host status code

    //////////////////////////////////////////////////
    // instances, ports matched by name
    //////////////////////////////////////////////////

    slot_if #(
        .index_t   (seq_cfg_pkg::slot_index_t),
        .addr_t    (seq_cfg_pkg::addr_t),
        .size_t    (seq_cfg_pkg::size_t),
        .status_t  (seq_cfg_pkg::slot_status_t),
        .profile_t (seq_cfg_pkg::profile_t)
    ) sif0 ();

    seq_ctrl_fsm u_fsm (.*);

    seq_slot_access u_access (
        .sif (sif0.access),
        .*
    );

    seq_slot_table u_table (
        .clk   (clk),
        .reset (reset),
        .sif   (sif0.tbl)
    );

endmodule

// ==== hdl/seq_ctrl_fsm.sv ====
`timescale 1ns/1ps

module seq_ctrl_fsm (
    input  logic                     clk,
    input  logic                     reset,           // async, active low
    input  seq_ctrl_pkg::ctrl_cmd_t  ctrl_cmd,
    input  logic                     ctrl_set,
    input  seq_cfg_pkg::slot_index_t end_cnt_in,
    input  logic                     end_cnt_set,
    input  logic                     reprog_accept,
    input  seq_cfg_pkg::init_task_t  init_done,       // one cycle per finished task
    input  logic                     exec_done,
    output seq_ctrl_pkg::seq_state_t state,
    output seq_cfg_pkg::slot_index_t slot_cnt,
    output seq_cfg_pkg::slot_index_t end_cnt_out,
    output logic                     reprog,
    output seq_cfg_pkg::init_task_t  init_task,
    output logic                     exec_start,
    output logic                     reprog_accepted  // profile inc strobe
);

    logic in_shutdown;
    assign in_shutdown = (state == seq_ctrl_pkg::st_shutdown);

    //////////////////////////////////////////////////
    // end count, host writable in shutdown only
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            end_cnt_out <= '0;
        end else if (end_cnt_set && in_shutdown) begin
            end_cnt_out <= end_cnt_in;
        end
    end

    // a host command in the same cycle blocks the step
    assign reprog_accepted = !ctrl_set && (state == seq_ctrl_pkg::st_reprog) && reprog_accept;

    //////////////////////////////////////////////////
    // run state machine
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state     <= seq_ctrl_pkg::st_shutdown;
            slot_cnt  <= '0;
            init_task <= '0;
        end else if (ctrl_set) begin
            case (ctrl_cmd)
                seq_ctrl_pkg::cmd_clear: begin
                    state     <= seq_ctrl_pkg::st_shutdown;
                    slot_cnt  <= '0;
                    init_task <= '0;
                end
                seq_ctrl_pkg::cmd_shutdown: state <= seq_ctrl_pkg::st_shutdown;  // cnt kept
                seq_ctrl_pkg::cmd_start: begin
                    if (in_shutdown) begin
                        state    <= seq_ctrl_pkg::st_reprog;
                        slot_cnt <= '0;  // always from slot 0
                    end
                end
                default: ;  // unknown command, hold
            endcase
        end else begin
            case (state)
                seq_ctrl_pkg::st_reprog: begin
                    if (reprog_accept) begin
                        state     <= seq_ctrl_pkg::st_init;
                        init_task <= seq_cfg_pkg::init_task_t'(1);  // first setup task
                    end
                end
                seq_ctrl_pkg::st_init: begin
                    if (init_done[seq_cfg_pkg::init_task_n-1]) begin
                        state     <= seq_ctrl_pkg::st_trigger;  // last task done
                        init_task <= '0;
                    end else if (init_done != '0) begin
                        init_task <= init_task << 1;  // next task
                    end
                end
                seq_ctrl_pkg::st_trigger: state <= seq_ctrl_pkg::st_wait_fin;  // single cycle
                seq_ctrl_pkg::st_wait_fin: begin
                    if (exec_done) begin
                        if (slot_cnt < end_cnt_out) begin
                            slot_cnt <= slot_cnt + 1'b1;
                            state    <= seq_ctrl_pkg::st_reprog;
                        end else begin
                            // last slot, back to idle
                            slot_cnt <= '0;
                            state    <= seq_ctrl_pkg::st_shutdown;
                        end
                    end
                end
                default: ;  // shutdown waits for a start
            endcase
        end
    end

    assign reprog     = (state == seq_ctrl_pkg::st_reprog);   // level until accepted
    assign exec_start = (state == seq_ctrl_pkg::st_trigger);  // one cycle pulse

endmodule

// ==== hdl/seq_slot_access.sv ====
`timescale 1ns/1ps

module seq_slot_access (
    input  seq_ctrl_pkg::seq_state_t  state,
    input  seq_cfg_pkg::slot_index_t  slot_cnt,
    input  logic                      reprog_accepted,  // one cycle, from the fsm
    // host write
    input  seq_cfg_pkg::slot_index_t  wr_index,
    input  seq_cfg_pkg::addr_t        wr_src_addr,
    input  seq_cfg_pkg::size_t        wr_src_size,
    input  seq_cfg_pkg::addr_t        wr_dst_addr,
    input  seq_cfg_pkg::size_t        wr_dst_size,
    input  seq_cfg_pkg::slot_status_t wr_status,
    input  seq_cfg_pkg::profile_t     wr_profile,
    input  logic                      set_src_addr,
    input  logic                      set_src_size,
    input  logic                      set_dst_addr,
    input  logic                      set_dst_size,
    input  logic                      set_status,
    input  logic                      set_profile,
    output logic                      set_done_src_addr,
    output logic                      set_done_src_size,
    output logic                      set_done_dst_addr,
    output logic                      set_done_dst_size,
    output logic                      set_done_status,
    output logic                      set_done_profile,
    // host read
    input  seq_cfg_pkg::slot_index_t  rd_index,
    input  logic                      rd_req,
    output logic                      rd_ready,
    output seq_cfg_pkg::addr_t        rd_src_addr,
    output seq_cfg_pkg::size_t        rd_src_size,
    output seq_cfg_pkg::addr_t        rd_dst_addr,
    output seq_cfg_pkg::size_t        rd_dst_size,
    output seq_cfg_pkg::slot_status_t rd_status,
    output seq_cfg_pkg::profile_t     rd_profile,
    // current slot toward the dma
    output seq_cfg_pkg::addr_t        dma_src_addr,
    output seq_cfg_pkg::size_t        dma_src_size,
    output seq_cfg_pkg::addr_t        dma_dst_addr,
    output seq_cfg_pkg::size_t        dma_dst_size,
    output seq_cfg_pkg::slot_status_t dma_status,
    output seq_cfg_pkg::profile_t     dma_profile,
    slot_if.access                    sif
);

    logic host_own;  // host owns the table only while shut down
    assign host_own = (state == seq_ctrl_pkg::st_shutdown);

    //////////////////////////////////////////////////
    // write path
    //////////////////////////////////////////////////

    assign set_done_src_addr = set_src_addr & host_own;  // same cycle ack
    assign set_done_src_size = set_src_size & host_own;
    assign set_done_dst_addr = set_dst_addr & host_own;
    assign set_done_dst_size = set_dst_size & host_own;
    assign set_done_status   = set_status   & host_own;
    assign set_done_profile  = set_profile  & host_own;

    assign sif.wr_index    = host_own ? wr_index : slot_cnt;
    assign sif.wr_src_addr = wr_src_addr;
    assign sif.wr_src_size = wr_src_size;
    assign sif.wr_dst_addr = wr_dst_addr;
    assign sif.wr_dst_size = wr_dst_size;
    assign sif.wr_status   = wr_status;
    // profile is shared between host and auto inc, never both in one cycle
    assign sif.wr_profile  = reprog_accepted ?
                             seq_cfg_pkg::profile_t'(sif.rd_profile + 1'b1) : wr_profile;

    assign sif.we_src_addr = set_done_src_addr;
    assign sif.we_src_size = set_done_src_size;
    assign sif.we_dst_addr = set_done_dst_addr;
    assign sif.we_dst_size = set_done_dst_size;
    assign sif.we_status   = set_done_status;
    assign sif.we_profile  = set_done_profile | reprog_accepted;

    //////////////////////////////////////////////////
    // read path, fanned out to host and dma
    //////////////////////////////////////////////////

    assign sif.rd_index = host_own ? rd_index : slot_cnt;  // run follows the counter
    assign rd_ready     = rd_req & host_own;

    assign rd_src_addr = sif.rd_src_addr;
    assign rd_src_size = sif.rd_src_size;
    assign rd_dst_addr = sif.rd_dst_addr;
    assign rd_dst_size = sif.rd_dst_size;
    assign rd_status   = sif.rd_status;
    assign rd_profile  = sif.rd_profile;

    assign dma_src_addr = sif.rd_src_addr;
    assign dma_src_size = sif.rd_src_size;
    assign dma_dst_addr = sif.rd_dst_addr;
    assign dma_dst_size = sif.rd_dst_size;
    assign dma_status   = sif.rd_status;
    assign dma_profile  = sif.rd_profile;

endmodule

// ==== hdl/seq_slot_table.sv ====
`timescale 1ns/1ps

module seq_slot_table (
    input logic   clk,
    input logic   reset,  // async, active low
    slot_if.tbl   sif
);

    //////////////////////////////////////////////////
    // slot storage, one array per field
    //////////////////////////////////////////////////

    seq_cfg_pkg::addr_t        src_addr_q [seq_cfg_pkg::slot_n];
    seq_cfg_pkg::size_t        src_size_q [seq_cfg_pkg::slot_n];
    seq_cfg_pkg::addr_t        dst_addr_q [seq_cfg_pkg::slot_n];
    seq_cfg_pkg::size_t        dst_size_q [seq_cfg_pkg::slot_n];
    seq_cfg_pkg::slot_status_t status_q   [seq_cfg_pkg::slot_n];
    seq_cfg_pkg::profile_t     profile_q  [seq_cfg_pkg::slot_n];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            // every slot starts empty
            for (int i = 0; i < seq_cfg_pkg::slot_n; i++) begin
                src_addr_q[i] <= '0;
                src_size_q[i] <= '0;
                dst_addr_q[i] <= '0;
                dst_size_q[i] <= '0;
                status_q[i]   <= '0;
                profile_q[i]  <= '0;
            end
        end else begin
            // fields are independent, any mix can land in one edge
            if (sif.we_src_addr) src_addr_q[sif.wr_index] <= sif.wr_src_addr;
            if (sif.we_src_size) src_size_q[sif.wr_index] <= sif.wr_src_size;
            if (sif.we_dst_addr) dst_addr_q[sif.wr_index] <= sif.wr_dst_addr;
            if (sif.we_dst_size) dst_size_q[sif.wr_index] <= sif.wr_dst_size;
            if (sif.we_status)   status_q[sif.wr_index]   <= sif.wr_status;
            if (sif.we_profile)  profile_q[sif.wr_index]  <= sif.wr_profile;  // host or auto inc
        end
    end

    //////////////////////////////////////////////////
    // read port, zero cycle
    //////////////////////////////////////////////////

    assign sif.rd_src_addr = src_addr_q[sif.rd_index];
    assign sif.rd_src_size = src_size_q[sif.rd_index];
    assign sif.rd_dst_addr = dst_addr_q[sif.rd_index];
    assign sif.rd_dst_size = dst_size_q[sif.rd_index];
    assign sif.rd_status   = status_q[sif.rd_index];
    assign sif.rd_profile  = profile_q[sif.rd_index];  // also feeds the +1 path

endmodule

// ==== hdl/slot_if.sv ====
`timescale 1ns/1ps

// write port and read port of the slot table
// types come in from the instantiating level
interface slot_if #(
    parameter type index_t   = logic,
    parameter type addr_t    = logic,
    parameter type size_t    = logic,
    parameter type status_t  = logic,
    parameter type profile_t = logic
);

    // write side, lands at the clock edge
    index_t   wr_index;
    addr_t    wr_src_addr;
    size_t    wr_src_size;
    addr_t    wr_dst_addr;
    size_t    wr_dst_size;
    status_t  wr_status;
    profile_t wr_profile;

    logic we_src_addr;  // one enable per field
    logic we_src_size;
    logic we_dst_addr;
    logic we_dst_size;
    logic we_status;
    logic we_profile;

    // read side, combinational from rd_index
    index_t   rd_index;
    addr_t    rd_src_addr;
    size_t    rd_src_size;
    addr_t    rd_dst_addr;
    size_t    rd_dst_size;
    status_t  rd_status;
    profile_t rd_profile;

    modport access (
        output wr_index, wr_src_addr, wr_src_size, wr_dst_addr, wr_dst_size,
        output wr_status, wr_profile,
        output we_src_addr, we_src_size, we_dst_addr, we_dst_size, we_status, we_profile,
        output rd_index,
        input  rd_src_addr, rd_src_size, rd_dst_addr, rd_dst_size, rd_status, rd_profile
    );

    modport tbl (
        input  wr_index, wr_src_addr, wr_src_size, wr_dst_addr, wr_dst_size,
        input  wr_status, wr_profile,
        input  we_src_addr, we_src_size, we_dst_addr, we_dst_size, we_status, we_profile,
        input  rd_index,
        output rd_src_addr, rd_src_size, rd_dst_addr, rd_dst_size, rd_status, rd_profile
    );

endinterface

// ==== hdl/seq_ctrl_pkg.sv ====
package seq_ctrl_pkg;

    localparam int state_w    = 4;  // same width as the host status word
    localparam int ctrl_cmd_w = 4;

    // encodings are what the host reads back on state_out
    typedef enum logic [state_w-1:0] {
        st_shutdown = 4'd0,   // idle, host owns the slot table
        st_reprog   = 4'd1,   // waiting for reprogram accept
        st_init     = 4'd2,   // stepping through dma setup tasks
        st_trigger  = 4'd3,   // one cycle, exec start
        st_wait_fin = 4'd4    // waiting for exec done
    } seq_state_t;

    typedef logic [ctrl_cmd_w-1:0] ctrl_cmd_t;

    localparam ctrl_cmd_t cmd_clear    = 4'd0;  // shutdown + clear counter and tasks
    localparam ctrl_cmd_t cmd_shutdown = 4'd1;  // shutdown, counter kept
    localparam ctrl_cmd_t cmd_start    = 4'd2;  // only taken in shutdown

endpackage

// ==== hdl/seq_cfg_pkg.sv ====
package seq_cfg_pkg;

    //////////////////////////////////////////////////
    // slot table geometry
    //////////////////////////////////////////////////

    localparam int slot_index_w = 2;                  // 2 ^ 2 = 4 slots
    localparam int slot_n       = 1 << slot_index_w;  // number of slots in the table

    localparam int addr_w    = 32;  // src and dst address
    localparam int size_w    = 26;  // transfer size in bytes
    localparam int status_w  = 2;
    localparam int profile_w = 32;  // reprogram counter per slot

    typedef logic [slot_index_w-1:0] slot_index_t;  // slot index, slot counter, end count
    typedef logic [addr_w-1:0]       addr_t;
    typedef logic [size_w-1:0]       size_t;
    typedef logic [status_w-1:0]     slot_status_t;
    typedef logic [profile_w-1:0]    profile_t;

    //////////////////////////////////////////////////
    // dma side
    //////////////////////////////////////////////////

    // (src addr + size) + (dst addr + size) + status + kick
    localparam int init_task_n = 6;

    typedef logic [init_task_n-1:0] init_task_t;    // one-hot, bit 0 first

endpackage
